//--- tb.f
+incdir+include
+incdir+testbench
hw/turf_pkg.sv
hw/turf_ctrl_regs.sv
hw/turfio_port.sv
hw/turfio_status.sv
hw/turf_gpo_mux.sv
hw/turf_housekeeping.sv
testbench/tb_turf_housekeeping.sv

//--- Bender.yml
package:
  name: turf_housekeeping

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/turf_pkg.sv
      - hw/turf_ctrl_regs.sv
      - hw/turfio_port.sv
      - hw/turfio_status.sv
      - hw/turf_gpo_mux.sv
      - hw/turf_housekeeping.sv
  - target: test
    include_dirs:
      - include
      - testbench
    files:
      - testbench/tb_turf_housekeeping.sv

//--- testbench/tb_turf_vectors.svh
`ifndef TB_TURF_VECTORS_SVH
`define TB_TURF_VECTORS_SVH

// Row operations
localparam logic [2:0] OP_WR    = 3'd0;
localparam logic [2:0] OP_RD    = 3'd1;
localparam logic [2:0] OP_PINS  = 3'd2;
localparam logic [2:0] OP_CRATE = 3'd3;
localparam logic [2:0] OP_GPO   = 3'd4;

// Columns are op, addr, data, mask and exp
//   OP_WR     write data to addr, exp is tio_reset_oe_o afterwards
//   OP_RD     read addr, compare the read data under mask with exp
//   OP_PINS   data[3:0] pins, data[7:4] link-up, poll status until it matches
//   OP_CRATE  crate access to link data[1:0]
//   OP_GPO    ce pulse on source data[2:0] with d = data[4], exp is gpo_o
typedef struct packed {
    logic [2:0]  op;
    logic [3:0]  addr;
    logic [31:0] data;
    logic [31:0] mask;
    logic [31:0] exp;
} vec_row_t;

// Bridge types of links 0 to 3 are none, aurora, aurora and reserved
localparam logic [31:0] BRIDGE_MIX =
    (32'(`TURF_BRIDGE_NONE)   << (`TURF_CTRL_BRIDGE_LSB + 0)) |
    (32'(`TURF_BRIDGE_AURORA) << (`TURF_CTRL_BRIDGE_LSB + 2)) |
    (32'(`TURF_BRIDGE_AURORA) << (`TURF_CTRL_BRIDGE_LSB + 4)) |
    (32'(2'd3)                << (`TURF_CTRL_BRIDGE_LSB + 6));

vec_row_t vectors[$];

function automatic logic [31:0] ctrl_word(input logic [3:0] rel, input logic [31:0] bridges,
                                          input logic en, input logic [2:0] sel);
    ctrl_word = (32'(rel) << `TURF_CTRL_RELEASE_LSB) | bridges |
                (32'(en) << `TURF_CTRL_GPO_EN_BIT) | (32'(sel) << `TURF_CTRL_GPO_SEL_LSB);
endfunction

function automatic void add_row(input logic [2:0] op, input logic [3:0] addr,
                                input logic [31:0] data, input logic [31:0] mask,
                                input logic [31:0] exp);
    vec_row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.mask = mask;
    r.exp  = exp;
    vectors.push_back(r);
endfunction

task automatic load_vectors();
    // Identity, version, status after reset, unknown address
    add_row(OP_RD, `TURF_ADDR_ID, 32'h0, 32'hFFFF_FFFF, `TURF_IDENT);
    add_row(OP_RD, `TURF_ADDR_DATEVER, 32'h0, 32'hFFFF_FFFF, `TURF_DATEVERSION);
    add_row(OP_RD, `TURF_ADDR_STATUS, 32'h0, 32'hFFFF_FFFF, 32'h0);
    add_row(OP_RD, 4'd7, 32'h0, 32'hFFFF_FFFF, 32'h0);
    // Release links 0 and 2 and try to overwrite the read-only identity
    add_row(OP_WR, `TURF_ADDR_CTRL, 32'h5, 32'hFFFF_FFFF, 32'hA);
    add_row(OP_RD, `TURF_ADDR_CTRL, 32'h0, 32'hFFFF_FFFF, 32'h5);
    add_row(OP_WR, `TURF_ADDR_ID, 32'hDEAD_BEEF, 32'hFFFF_FFFF, 32'hA);
    add_row(OP_RD, `TURF_ADDR_ID, 32'h0, 32'hFFFF_FFFF, `TURF_IDENT);
    add_row(OP_WR, `TURF_ADDR_CTRL, 32'hF, 32'hFFFF_FFFF, 32'h0);
    // Pins 1101 correct to 0001, then pins 0110 correct to 1010
    add_row(OP_PINS, 4'd0, 32'h0D, 32'hF, 32'(4'b1101 ^ `TURF_INV_GPIO));
    add_row(OP_RD, `TURF_ADDR_STATUS, 32'h0, 32'hFF, 32'h11);
    add_row(OP_PINS, 4'd0, 32'h06, 32'hF, 32'(4'b0110 ^ `TURF_INV_GPIO));
    add_row(OP_RD, `TURF_ADDR_STATUS, 32'h0, 32'hF0, 32'hB0);
    add_row(OP_WR, `TURF_ADDR_STATUS, 32'hF0, 32'hFFFF_FFFF, 32'h0);
    add_row(OP_RD, `TURF_ADDR_STATUS, 32'h0, 32'hFF, 32'h0A);
    // Bridge check with links 1 and 3 up
    add_row(OP_WR, `TURF_ADDR_CTRL, ctrl_word(4'hF, BRIDGE_MIX, 1'b0, 3'd0), 32'hF, 32'h0);
    add_row(OP_PINS, 4'd0, 32'hA6, 32'hF000, 32'hA000);
    add_row(OP_CRATE, 4'd0, 32'd0, 32'h0, 32'h0);
    add_row(OP_CRATE, 4'd0, 32'd1, 32'h0, 32'h0);
    add_row(OP_CRATE, 4'd0, 32'd2, 32'h0, 32'h0);
    add_row(OP_CRATE, 4'd0, 32'd3, 32'h0, 32'h0);
    add_row(OP_RD, `TURF_ADDR_STATUS, 32'h0, 32'hFF00, 32'hAC00);
    add_row(OP_WR, `TURF_ADDR_STATUS, 32'hF00, 32'hFFFF_FFFF, 32'h0);
    add_row(OP_CRATE, 4'd0, 32'd1, 32'h0, 32'h0);
    add_row(OP_RD, `TURF_ADDR_STATUS, 32'h0, 32'hF00, 32'h0);
    // GPO follows the trigger source only
    add_row(OP_WR, `TURF_ADDR_CTRL, ctrl_word(4'hF, BRIDGE_MIX, 1'b1, `TURF_GPO_TRIG),
            32'hF, 32'h0);
    add_row(OP_GPO, 4'd0, 32'h10 | 32'(`TURF_GPO_TRIG), 32'h1, 32'h1);
    add_row(OP_GPO, 4'd0, 32'(`TURF_GPO_SYNC), 32'h1, 32'h1);
    add_row(OP_GPO, 4'd0, 32'(`TURF_GPO_PPS), 32'h1, 32'h1);
    add_row(OP_GPO, 4'd0, 32'(`TURF_GPO_TRIG), 32'h1, 32'h0);
    add_row(OP_GPO, 4'd0, 32'h10 | 32'(`TURF_GPO_TRIG), 32'h1, 32'h1);
    // Unused select, then enable cleared
    add_row(OP_WR, `TURF_ADDR_CTRL, ctrl_word(4'hF, BRIDGE_MIX, 1'b1, 3'd5), 32'hF, 32'h0);
    add_row(OP_GPO, 4'd0, 32'h10 | 32'(`TURF_GPO_TRIG), 32'h1, 32'h0);
    add_row(OP_WR, `TURF_ADDR_CTRL, ctrl_word(4'hF, BRIDGE_MIX, 1'b1, `TURF_GPO_TRIG),
            32'hF, 32'h0);
    add_row(OP_GPO, 4'd0, 32'h10 | 32'(`TURF_GPO_TRIG), 32'h1, 32'h1);
    add_row(OP_WR, `TURF_ADDR_CTRL, ctrl_word(4'hF, BRIDGE_MIX, 1'b0, `TURF_GPO_TRIG),
            32'hF, 32'h0);
    add_row(OP_GPO, 4'd0, 32'h10 | 32'(`TURF_GPO_TRIG), 32'h1, 32'h0);
endtask

`endif

//--- testbench/tb_turf_housekeeping.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_consts.svh"

module tb_turf_housekeeping;
    import turf_pkg::*;

    localparam int POLL_LIMIT = 20;

    logic       ps_clk = 1'b0;
    logic       rst_n_i;
    logic       reg_wr_i;
    logic       reg_rd_i;
    reg_addr_t  reg_addr_i;
    reg_data_t  reg_wdata_i;
    reg_data_t  reg_rdata_o;
    logic       crate_access_i;
    logic [1:0] crate_tio_i;
    tio_mask_t  tio_gpio_i;
    tio_mask_t  link_up_i;
    tio_mask_t  tio_reset_oe_o;
    gpo_src_t   gpo_src_i;
    logic       gpo_o;

    int   errors;
    int   checks;
    logic aborted;

    `include "tb_turf_vectors.svh"

    always #4 ps_clk = ~ps_clk;

    turf_housekeeping DUT (
        .ps_clk         (ps_clk),
        .rst_n_i        (rst_n_i),
        .reg_wr_i       (reg_wr_i),
        .reg_rd_i       (reg_rd_i),
        .reg_addr_i     (reg_addr_i),
        .reg_wdata_i    (reg_wdata_i),
        .reg_rdata_o    (reg_rdata_o),
        .crate_access_i (crate_access_i),
        .crate_tio_i    (crate_tio_i),
        .tio_gpio_i     (tio_gpio_i),
        .link_up_i      (link_up_i),
        .tio_reset_oe_o (tio_reset_oe_o),
        .gpo_src_i      (gpo_src_i),
        .gpo_o          (gpo_o)
    );

    ////////////////////////////////////////
    // Bus helpers
    ////////////////////////////////////////

    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge ps_clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_wr_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        tick();
        reg_wr_i    = 1'b0;
    endtask

    // Read data is registered on the strobe edge
    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        reg_rd_i   = 1'b1;
        reg_addr_i = addr;
        tick();
        reg_rd_i   = 1'b0;
        data       = reg_rdata_o;
    endtask

    task automatic wait_status(input reg_data_t mask, input reg_data_t exp);
        reg_data_t data;
        int        polls;
        logic      done;
        done  = 1'b0;
        polls = 0;
        while (!done && polls < POLL_LIMIT) begin
            reg_read(`TURF_ADDR_STATUS, data);
            done = ((data & mask) == exp);
            polls++;
        end
        if (!done) begin
            aborted = 1'b1;
            $display("Status never reached %h under mask %h in %0d reads", exp, mask, polls);
        end
        check_value("status", data & mask, exp);
    endtask

    task automatic gpo_pulse(input logic [2:0] src, input logic d);
        gpo_src_i = '0;
        case (src)
            `TURF_GPO_SYNC: gpo_src_i.sync = '{ce: 1'b1, d: d};
            `TURF_GPO_RUN:  gpo_src_i.run  = '{ce: 1'b1, d: d};
            `TURF_GPO_TRIG: gpo_src_i.trig = '{ce: 1'b1, d: d};
            default:        gpo_src_i.pps  = '{ce: 1'b1, d: d};
        endcase
        tick();
        gpo_src_i = '0;
    endtask

    task automatic apply_row(input vec_row_t row);
        reg_data_t data;
        case (row.op)
            OP_WR: begin
                reg_write(row.addr, row.data);
                tick();
                check_value("tio_reset_oe_o", tio_reset_oe_o, row.exp);
            end
            OP_RD: begin
                reg_read(row.addr, data);
                check_value("reg_rdata_o", data & row.mask, row.exp);
            end
            OP_PINS: begin
                tio_gpio_i = row.data[3:0];
                link_up_i  = row.data[7:4];
                wait_status(row.mask, row.exp);
            end
            OP_CRATE: begin
                crate_access_i = 1'b1;
                crate_tio_i    = row.data[1:0];
                tick();
                crate_access_i = 1'b0;
                // Decode, then invalid pulse, then the sticky bit
                repeat (2) tick();
            end
            default: begin
                gpo_pulse(row.data[2:0], row.data[4]);
                check_value("gpo_o", gpo_o, row.exp);
            end
        endcase
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        rst_n_i        = 1'b0;
        reg_wr_i       = 1'b0;
        reg_rd_i       = 1'b0;
        reg_addr_i     = '0;
        reg_wdata_i    = '0;
        crate_access_i = 1'b0;
        crate_tio_i    = '0;
        // Pins at the inverted polarity, so every corrected level is low
        tio_gpio_i     = `TURF_INV_GPIO;
        link_up_i      = '0;
        gpo_src_i      = '0;
        errors         = 0;
        checks         = 0;
        aborted        = 1'b0;
        load_vectors();

        repeat (5) @(posedge ps_clk);
        #1;
        rst_n_i = 1'b1;
        // Let the synchronizers settle on the idle pins
        repeat (3) tick();
        check_value("tio_reset_oe_o", tio_reset_oe_o, 32'hF);
        check_value("gpo_o", gpo_o, 32'h0);

        for (int i = 0; i < vectors.size() && !aborted; i++) begin
            apply_row(vectors[i]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/turf_housekeeping.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_consts.svh"

module turf_housekeeping (
    input  logic                ps_clk,
    input  logic                rst_n_i,

    // Register strobes from the processor
    input  logic                reg_wr_i,
    input  logic                reg_rd_i,
    input  turf_pkg::reg_addr_t reg_addr_i,
    input  turf_pkg::reg_data_t reg_wdata_i,
    output turf_pkg::reg_data_t reg_rdata_o,

    // Crate access through the bridge
    input  logic                crate_access_i,
    input  logic [1:0]          crate_tio_i,

    // TURFIO pins
    input  turf_pkg::tio_mask_t tio_gpio_i,
    input  turf_pkg::tio_mask_t link_up_i,
    output turf_pkg::tio_mask_t tio_reset_oe_o,

    // General-purpose output
    input  turf_pkg::gpo_src_t  gpo_src_i,
    output logic                gpo_o
);
    import turf_pkg::*;

    localparam tio_mask_t INV_GPIO = `TURF_INV_GPIO;

    tio_ctrl_t [`TURF_NUM_TIO-1:0] tio_ctrl;
    tio_stat_t [`TURF_NUM_TIO-1:0] tio_stat;
    reg_data_t                     status_word;
    reg_data_t                     status_clr;
    logic                          gpo_en;
    gpo_sel_t                      gpo_sel;

    turf_ctrl_regs u_regs (
        .ps_clk         (ps_clk),
        .rst_n_i        (rst_n_i),
        .reg_wr_i       (reg_wr_i),
        .reg_rd_i       (reg_rd_i),
        .reg_addr_i     (reg_addr_i),
        .reg_wdata_i    (reg_wdata_i),
        .reg_rdata_o    (reg_rdata_o),
        .crate_access_i (crate_access_i),
        .crate_tio_i    (crate_tio_i),
        .status_i       (status_word),
        .status_clr_o   (status_clr),
        .tio_ctrl_o     (tio_ctrl),
        .gpo_en_o       (gpo_en),
        .gpo_sel_o      (gpo_sel)
    );

    ////////////////////////////////////////
    // TURFIO link slices
    ////////////////////////////////////////

    for (genvar i = 0; i < `TURF_NUM_TIO; i++) begin : g_tio
        turfio_port #(
            .INVERT (INV_GPIO[i])
        ) u_port (
            .ps_clk     (ps_clk),
            .rst_n_i    (rst_n_i),
            .ctrl_i     (tio_ctrl[i]),
            .gpio_pin_i (tio_gpio_i[i]),
            .link_up_i  (link_up_i[i]),
            .reset_oe_o (tio_reset_oe_o[i]),
            .stat_o     (tio_stat[i])
        );
    end

    turfio_status u_status (
        .ps_clk   (ps_clk),
        .rst_n_i  (rst_n_i),
        .stat_i   (tio_stat),
        .clr_i    (status_clr),
        .status_o (status_word)
    );

    turf_gpo_mux u_gpo (
        .ps_clk    (ps_clk),
        .rst_n_i   (rst_n_i),
        .gpo_en_i  (gpo_en),
        .gpo_sel_i (gpo_sel),
        .src_i     (gpo_src_i),
        .gpo_o     (gpo_o)
    );

endmodule

`default_nettype wire

//--- hw/turf_gpo_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_consts.svh"

module turf_gpo_mux (
    input  logic               ps_clk,
    input  logic               rst_n_i,
    input  logic               gpo_en_i,
    input  turf_pkg::gpo_sel_t gpo_sel_i,
    input  turf_pkg::gpo_src_t src_i,
    output logic               gpo_o
);
    logic sel_valid;
    logic sel_ce;
    logic sel_d;
    logic gpo_q;

    // Pick the strobe pair of the selected source
    always_comb begin
        sel_valid = 1'b1;
        sel_ce    = 1'b0;
        sel_d     = 1'b0;
        case (gpo_sel_i)
            `TURF_GPO_SYNC: begin
                sel_ce = src_i.sync.ce;
                sel_d  = src_i.sync.d;
            end
            `TURF_GPO_RUN: begin
                sel_ce = src_i.run.ce;
                sel_d  = src_i.run.d;
            end
            `TURF_GPO_TRIG: begin
                sel_ce = src_i.trig.ce;
                sel_d  = src_i.trig.d;
            end
            `TURF_GPO_PPS: begin
                sel_ce = src_i.pps.ce;
                sel_d  = src_i.pps.d;
            end
            default: sel_valid = 1'b0;
        endcase
    end

    // Output parks low when disabled or pointed at an unused source
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i || !gpo_en_i || !sel_valid) begin
            gpo_q <= 1'b0;
        end else if (sel_ce) begin
            gpo_q <= sel_d;
        end
    end

    assign gpo_o = gpo_q;

endmodule

`default_nettype wire

//--- hw/turfio_status.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_consts.svh"

module turfio_status (
    input  logic                                       ps_clk,
    input  logic                                       rst_n_i,
    input  turf_pkg::tio_stat_t [`TURF_NUM_TIO-1:0]    stat_i,
    input  turf_pkg::reg_data_t                        clr_i,
    output turf_pkg::reg_data_t                        status_o
);
    import turf_pkg::*;

    tio_mask_t level_vec;
    tio_mask_t rise_vec;
    tio_mask_t invalid_vec;
    tio_mask_t link_vec;
    tio_mask_t rise_clr;
    tio_mask_t invalid_clr;
    tio_mask_t rise_sticky_q;
    tio_mask_t invalid_sticky_q;

    // Gather the slices into per-field vectors
    always_comb begin
        for (int i = 0; i < `TURF_NUM_TIO; i++) begin
            level_vec[i]   = stat_i[i].level;
            rise_vec[i]    = stat_i[i].rise;
            invalid_vec[i] = stat_i[i].invalid;
            link_vec[i]    = stat_i[i].link_up;
        end
    end

    assign rise_clr    = clr_i[`TURF_STAT_RISE_LSB +: `TURF_NUM_TIO];
    assign invalid_clr = clr_i[`TURF_STAT_INVALID_LSB +: `TURF_NUM_TIO];

    ////////////////////////////////////////
    // Sticky flags
    ////////////////////////////////////////

    // A new event in the same cycle as its clear keeps the bit set
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            rise_sticky_q    <= '0;
            invalid_sticky_q <= '0;
        end else begin
            rise_sticky_q    <= (rise_sticky_q & ~rise_clr) | rise_vec;
            invalid_sticky_q <= (invalid_sticky_q & ~invalid_clr) | invalid_vec;
        end
    end

    // Status word, upper half reads as zero
    always_comb begin
        status_o = '0;
        status_o[`TURF_STAT_LEVEL_LSB   +: `TURF_NUM_TIO] = level_vec;
        status_o[`TURF_STAT_RISE_LSB    +: `TURF_NUM_TIO] = rise_sticky_q;
        status_o[`TURF_STAT_INVALID_LSB +: `TURF_NUM_TIO] = invalid_sticky_q;
        status_o[`TURF_STAT_LINKUP_LSB  +: `TURF_NUM_TIO] = link_vec;
    end

endmodule

`default_nettype wire

//--- hw/turfio_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_consts.svh"

module turfio_port #(
    parameter bit INVERT = 1'b0
) (
    input  logic                ps_clk,
    input  logic                rst_n_i,
    input  turf_pkg::tio_ctrl_t ctrl_i,
    input  logic                gpio_pin_i,
    input  logic                link_up_i,
    output logic                reset_oe_o,
    output turf_pkg::tio_stat_t stat_o
);
    logic reset_oe_q;
    logic gpio_meta_q;
    logic level_next;
    logic level_q;
    logic rise_q;
    logic link_meta_q;
    logic link_up_q;
    logic bridge_ok;
    logic invalid_q;

    // Open-drain reset line is pulled low while the enable is high
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            reset_oe_q <= 1'b1;
        end else begin
            reset_oe_q <= ~ctrl_i.release_link;
        end
    end

    ////////////////////////////////////////
    // GPIO capture
    ////////////////////////////////////////

    // Second synchronizer stage also applies the board polarity
    assign level_next = gpio_meta_q ^ INVERT;

    // First stage starts at the idle pin level so the corrected level starts low
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            gpio_meta_q <= INVERT;
            level_q     <= 1'b0;
            rise_q      <= 1'b0;
        end else begin
            gpio_meta_q <= gpio_pin_i;
            level_q     <= level_next;
            rise_q      <= level_next & ~level_q;
        end
    end

    ////////////////////////////////////////
    // Bridge validity
    ////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            link_meta_q <= 1'b0;
            link_up_q   <= 1'b0;
            invalid_q   <= 1'b0;
        end else begin
            link_meta_q <= link_up_i;
            link_up_q   <= link_meta_q;
            invalid_q   <= ctrl_i.access & ~bridge_ok;
        end
    end

    // No bridge is always valid and aurora needs its link up
    always_comb begin
        case (ctrl_i.bridge)
            `TURF_BRIDGE_NONE:   bridge_ok = 1'b1;
            `TURF_BRIDGE_AURORA: bridge_ok = link_up_q;
            default:             bridge_ok = 1'b0;
        endcase
    end

    assign reset_oe_o     = reset_oe_q;
    assign stat_o.level   = level_q;
    assign stat_o.rise    = rise_q;
    assign stat_o.invalid = invalid_q;
    assign stat_o.link_up = link_up_q;

endmodule

`default_nettype wire

//--- hw/turf_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_consts.svh"

module turf_ctrl_regs (
    input  logic                                       ps_clk,
    input  logic                                       rst_n_i,
    input  logic                                       reg_wr_i,
    input  logic                                       reg_rd_i,
    input  turf_pkg::reg_addr_t                        reg_addr_i,
    input  turf_pkg::reg_data_t                        reg_wdata_i,
    output turf_pkg::reg_data_t                        reg_rdata_o,
    input  logic                                       crate_access_i,
    input  logic [1:0]                                 crate_tio_i,
    input  turf_pkg::reg_data_t                        status_i,
    output turf_pkg::reg_data_t                        status_clr_o,
    output turf_pkg::tio_ctrl_t [`TURF_NUM_TIO-1:0]    tio_ctrl_o,
    output logic                                       gpo_en_o,
    output turf_pkg::gpo_sel_t                         gpo_sel_o
);
    import turf_pkg::*;

    logic [`TURF_CTRL_WIDTH-1:0] ctrl_q;
    tio_mask_t                   access_q;

    ////////////////////////////////////////
    // Control word
    ////////////////////////////////////////

    // Zero after reset, so every link starts held in reset
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else if (reg_wr_i && reg_addr_i == `TURF_ADDR_CTRL) begin
            ctrl_q <= reg_wdata_i[`TURF_CTRL_WIDTH-1:0];
        end
    end

    // Write-one-to-clear of the sticky status bits, a pulse as long as the strobe
    assign status_clr_o = (reg_wr_i && reg_addr_i == `TURF_ADDR_STATUS) ? reg_wdata_i : '0;

    ////////////////////////////////////////
    // Register reads
    ////////////////////////////////////////

    // Read data is held until the next read strobe
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            reg_rdata_o <= '0;
        end else if (reg_rd_i) begin
            case (reg_addr_i)
                `TURF_ADDR_ID:      reg_rdata_o <= `TURF_IDENT;
                `TURF_ADDR_DATEVER: reg_rdata_o <= `TURF_DATEVERSION;
                `TURF_ADDR_CTRL:    reg_rdata_o <= reg_data_t'(ctrl_q);
                `TURF_ADDR_STATUS:  reg_rdata_o <= status_i;
                default:            reg_rdata_o <= '0;
            endcase
        end
    end

    ////////////////////////////////////////
    // Crate access decode
    ////////////////////////////////////////

    // One-hot on the link addressed by the crate, one cycle after the strobe
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            access_q <= '0;
        end else begin
            access_q <= '0;
            if (crate_access_i) begin
                access_q[crate_tio_i] <= 1'b1;
            end
        end
    end

    // Per-link view of the control fields
    always_comb begin
        for (int i = 0; i < `TURF_NUM_TIO; i++) begin
            tio_ctrl_o[i].release_link = ctrl_q[`TURF_CTRL_RELEASE_LSB + i];
            tio_ctrl_o[i].bridge =
                ctrl_q[`TURF_CTRL_BRIDGE_LSB + $bits(bridge_sel_t)*i +: $bits(bridge_sel_t)];
            tio_ctrl_o[i].access = access_q[i];
        end
    end

    assign gpo_en_o  = ctrl_q[`TURF_CTRL_GPO_EN_BIT];
    assign gpo_sel_o = ctrl_q[`TURF_CTRL_GPO_SEL_LSB +: $bits(gpo_sel_t)];

endmodule

`default_nettype wire

//--- hw/turf_pkg.sv
`default_nettype none

`include "turf_consts.svh"

package turf_pkg;

    ////////////////////////////////////////
    // Plain vector types
    ////////////////////////////////////////

    // Register word address and data
    typedef logic [3:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // One bit per TURFIO link
    typedef logic [`TURF_NUM_TIO-1:0] tio_mask_t;

    // Bridge type of one link
    typedef logic [1:0] bridge_sel_t;

    // GPO source select, codes above PPS give a low output
    typedef logic [2:0] gpo_sel_t;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // Register block to one link slice
    typedef struct packed {
        logic        release_link;
        bridge_sel_t bridge;
        logic        access;
    } tio_ctrl_t;

    // One link slice to the status collector
    typedef struct packed {
        logic level;
        logic rise;
        logic invalid;
        logic link_up;
    } tio_stat_t;

    // A strobe source for the GPO: clock enable and its data
    typedef struct packed {
        logic ce;
        logic d;
    } gpo_strobe_t;

    typedef struct packed {
        gpo_strobe_t sync;
        gpo_strobe_t run;
        gpo_strobe_t trig;
        gpo_strobe_t pps;
    } gpo_src_t;

endpackage

`default_nettype wire

//--- include/turf_consts.svh
`ifndef TURF_CONSTS_SVH
`define TURF_CONSTS_SVH

// Number of TURFIO links on the crate
`define TURF_NUM_TIO            4

// Register word addresses
`define TURF_ADDR_ID            4'd0
`define TURF_ADDR_DATEVER       4'd1
`define TURF_ADDR_CTRL          4'd2
`define TURF_ADDR_STATUS        4'd3

// Identity is ASCII "TURF"; version 0.8.8 sits in the low half
`define TURF_IDENT              32'h5455_5246
`define TURF_DATEVERSION        32'h0000_0808

// Board polarity of the TURFIO GPIO inputs, bit 3 is link D
`define TURF_INV_GPIO           4'b1100

// Crate bridge types, codes 2 and 3 are not implemented
`define TURF_BRIDGE_NONE        2'd0
`define TURF_BRIDGE_AURORA      2'd1

// General-purpose output sources
`define TURF_GPO_SYNC           3'd0
`define TURF_GPO_RUN            3'd1
`define TURF_GPO_TRIG           3'd2
`define TURF_GPO_PPS            3'd3

// Control word layout
`define TURF_CTRL_WIDTH         16
`define TURF_CTRL_RELEASE_LSB   0
`define TURF_CTRL_BRIDGE_LSB    4
`define TURF_CTRL_GPO_EN_BIT    12
`define TURF_CTRL_GPO_SEL_LSB   13

// Status word layout
`define TURF_STAT_LEVEL_LSB     0
`define TURF_STAT_RISE_LSB      4
`define TURF_STAT_INVALID_LSB   8
`define TURF_STAT_LINKUP_LSB    12

`endif
